// ==== include/exu_settings.svh ====
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// datapath and pc width
`define EXU_XLEN 32

// architectural register index width
`define EXU_REG_BITS 5

`endif

// ==== hw/exu_pkg.sv ====
`include "exu_settings.svh"

package exu_pkg;

    // one instruction word, read as 3R or as 2RI12
    typedef union packed {
        struct packed {
            logic [16:0]              opcode;
            logic [`EXU_REG_BITS-1:0] rk;
            logic [`EXU_REG_BITS-1:0] rj;
            logic [`EXU_REG_BITS-1:0] rd;
        } r3;
        struct packed {
            logic [9:0]               opcode;
            logic [11:0]              imm;
            logic [`EXU_REG_BITS-1:0] rj;
            logic [`EXU_REG_BITS-1:0] rd;
        } ri12;
    } exu_inst_t;

    // immediates map onto add, slt, and, or
    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_SLT,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_MUL_LO,
        UOP_MULH_S,
        UOP_MULH_U,
        UOP_NOP
    } exu_uop_t;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;
    localparam logic [16:0] OP_MUL_W   = 17'h00038;
    localparam logic [16:0] OP_MULH_W  = 17'h00039;
    localparam logic [16:0] OP_MULH_WU = 17'h0003a;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;

    // instruction not exist
    localparam logic [6:0] EXC_INE = 7'h0d;

endpackage

// ==== hw/exu_decode.sv ====
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_decode import exu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`EXU_XLEN-1:0]     in_pc,
    input  logic [`EXU_XLEN-1:0]     in_inst,
    input  logic [`EXU_XLEN-1:0]     in_rj_data,
    input  logic [`EXU_XLEN-1:0]     in_rk_data,
    output logic                     dec_valid,
    input  logic                     dec_ready,
    output logic [`EXU_XLEN-1:0]     dec_pc,
    output exu_uop_t                 dec_uop,
    output logic [`EXU_XLEN-1:0]     dec_src1,
    output logic [`EXU_XLEN-1:0]     dec_src2,
    output logic [`EXU_REG_BITS-1:0] dec_rd,
    output logic                     dec_excp_flag
);

    exu_inst_t             inst;
    exu_uop_t              uop;
    logic [`EXU_XLEN-1:0]  imm_sext;
    logic [`EXU_XLEN-1:0]  imm_zext;
    logic [`EXU_XLEN-1:0]  src2;
    logic                  excp;

    assign inst     = in_inst;
    assign imm_sext = {{(`EXU_XLEN-12){inst.ri12.imm[11]}}, inst.ri12.imm};
    assign imm_zext = {{(`EXU_XLEN-12){1'b0}}, inst.ri12.imm};

    // 3R match first, 2RI12 only when that fails
    always_comb begin
        uop  = UOP_NOP;
        src2 = in_rk_data;
        excp = 1'b0;
        case (inst.r3.opcode)
            OP_ADD_W:   uop = UOP_ADD;
            OP_SUB_W:   uop = UOP_SUB;
            OP_SLT:     uop = UOP_SLT;
            OP_AND:     uop = UOP_AND;
            OP_OR:      uop = UOP_OR;
            OP_XOR:     uop = UOP_XOR;
            OP_MUL_W:   uop = UOP_MUL_LO;
            OP_MULH_W:  uop = UOP_MULH_S;
            OP_MULH_WU: uop = UOP_MULH_U;
            default: begin
                case (inst.ri12.opcode)
                    OP_SLTI:   begin uop = UOP_SLT; src2 = imm_sext; end
                    OP_ADDI_W: begin uop = UOP_ADD; src2 = imm_sext; end
                    // logical immediates are zero extended
                    OP_ANDI:   begin uop = UOP_AND; src2 = imm_zext; end
                    OP_ORI:    begin uop = UOP_OR;  src2 = imm_zext; end
                    default:   excp = 1'b1;
                endcase
            end
        endcase
    end

    // one-entry slot
    assign in_ready = ~dec_valid | dec_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_pc        <= in_pc;
            dec_uop       <= uop;
            dec_src1      <= in_rj_data;
            dec_src2      <= src2;
            dec_rd        <= inst.r3.rd;
            dec_excp_flag <= excp;
        end
    end

endmodule

// ==== hw/exu_ex1.sv ====
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_ex1 import exu_pkg::*; (
    input  exu_uop_t             uop,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] src2,
    output logic [`EXU_XLEN-1:0] alu_result,
    output logic [`EXU_XLEN-1:0] mul_ll,
    output logic [`EXU_XLEN-1:0] mul_lh,
    output logic [`EXU_XLEN-1:0] mul_hl,
    output logic [`EXU_XLEN-1:0] mul_hh,
    output logic [`EXU_XLEN-1:0] mul_compensate
);

    localparam int HALF = `EXU_XLEN / 2;

    logic [HALF-1:0]      a_lo;
    logic [HALF-1:0]      a_hi;
    logic [HALF-1:0]      b_lo;
    logic [HALF-1:0]      b_hi;
    logic [`EXU_XLEN-1:0] comp_a;
    logic [`EXU_XLEN-1:0] comp_b;

    always_comb begin
        case (uop)
            UOP_ADD: alu_result = src1 + src2;
            UOP_SUB: alu_result = src1 - src2;
            UOP_SLT: begin
                alu_result = {{(`EXU_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            UOP_AND: alu_result = src1 & src2;
            UOP_OR:  alu_result = src1 | src2;
            UOP_XOR: alu_result = src1 ^ src2;
            // multiplies and nop take their result elsewhere
            default: alu_result = '0;
        endcase
    end

    assign a_lo = src1[HALF-1:0];
    assign a_hi = src1[`EXU_XLEN-1:HALF];
    assign b_lo = src2[HALF-1:0];
    assign b_hi = src2[`EXU_XLEN-1:HALF];

    // unsigned 16x16 partial products
    assign mul_ll = `EXU_XLEN'(a_lo) * `EXU_XLEN'(b_lo);
    assign mul_lh = `EXU_XLEN'(a_lo) * `EXU_XLEN'(b_hi);
    assign mul_hl = `EXU_XLEN'(a_hi) * `EXU_XLEN'(b_lo);
    assign mul_hh = `EXU_XLEN'(a_hi) * `EXU_XLEN'(b_hi);

    /*
     * signed high word = unsigned high word minus the operands whose
     * partner is negative, all modulo 2^32
     */
    assign comp_a = src1[`EXU_XLEN-1] ? src2 : '0;
    assign comp_b = src2[`EXU_XLEN-1] ? src1 : '0;

    assign mul_compensate = (uop == UOP_MULH_S) ? comp_a + comp_b : '0;

endmodule

// ==== hw/exu_ex1_ex2.sv ====
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_ex1_ex2 import exu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     dec_valid,
    output logic                     dec_ready,
    input  logic [`EXU_XLEN-1:0]     dec_pc,
    input  exu_uop_t                 dec_uop,
    input  logic [`EXU_REG_BITS-1:0] dec_rd,
    input  logic                     dec_excp_flag,
    input  logic [`EXU_XLEN-1:0]     alu_result,
    input  logic [`EXU_XLEN-1:0]     mul_ll,
    input  logic [`EXU_XLEN-1:0]     mul_lh,
    input  logic [`EXU_XLEN-1:0]     mul_hl,
    input  logic [`EXU_XLEN-1:0]     mul_hh,
    input  logic [`EXU_XLEN-1:0]     mul_compensate,
    output logic                     ex2_valid,
    input  logic                     ex2_ready,
    output logic [`EXU_XLEN-1:0]     ex2_pc,
    output exu_uop_t                 ex2_uop,
    output logic [`EXU_REG_BITS-1:0] ex2_rd,
    output logic                     ex2_excp_flag,
    output logic [`EXU_XLEN-1:0]     ex2_alu_result,
    output logic [`EXU_XLEN-1:0]     ex2_mul_ll,
    output logic [`EXU_XLEN-1:0]     ex2_mul_lh,
    output logic [`EXU_XLEN-1:0]     ex2_mul_hl,
    output logic [`EXU_XLEN-1:0]     ex2_mul_hh,
    output logic [`EXU_XLEN-1:0]     ex2_mul_compensate
);

    logic load;

    // accept when empty or when the result stage drains us
    assign dec_ready = ~ex2_valid | ex2_ready;
    assign load      = dec_valid & dec_ready;

    // bubble when drained with nothing new behind
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ex2_valid <= 1'b0;
        end else if (dec_ready) begin
            ex2_valid <= dec_valid;
        end
    end

    // payload holds while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            ex2_pc             <= dec_pc;
            ex2_uop            <= dec_uop;
            ex2_rd             <= dec_rd;
            ex2_excp_flag      <= dec_excp_flag;
            ex2_alu_result     <= alu_result;
            ex2_mul_ll         <= mul_ll;
            ex2_mul_lh         <= mul_lh;
            ex2_mul_hl         <= mul_hl;
            ex2_mul_hh         <= mul_hh;
            ex2_mul_compensate <= mul_compensate;
        end
    end

endmodule

// ==== hw/exu_result.sv ====
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_result import exu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     ex2_valid,
    output logic                     ex2_ready,
    input  logic [`EXU_XLEN-1:0]     ex2_pc,
    input  exu_uop_t                 ex2_uop,
    input  logic [`EXU_REG_BITS-1:0] ex2_rd,
    input  logic                     ex2_excp_flag,
    input  logic [`EXU_XLEN-1:0]     ex2_alu_result,
    input  logic [`EXU_XLEN-1:0]     ex2_mul_ll,
    input  logic [`EXU_XLEN-1:0]     ex2_mul_lh,
    input  logic [`EXU_XLEN-1:0]     ex2_mul_hl,
    input  logic [`EXU_XLEN-1:0]     ex2_mul_hh,
    input  logic [`EXU_XLEN-1:0]     ex2_mul_compensate,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`EXU_XLEN-1:0]     out_pc,
    output logic [`EXU_REG_BITS-1:0] out_rd,
    output logic [`EXU_XLEN-1:0]     out_data,
    output logic                     out_excp_flag,
    output logic [6:0]               out_exception
);

    localparam int HALF = `EXU_XLEN / 2;
    localparam int PW   = 2 * `EXU_XLEN;

    logic [PW-1:0]        product;
    logic [`EXU_XLEN-1:0] prod_hi;
    logic [`EXU_XLEN-1:0] result;

    // hh at 2^32, cross terms at 2^16
    assign product = (PW'(ex2_mul_hh) << `EXU_XLEN)
                   + (PW'(ex2_mul_lh) << HALF)
                   + (PW'(ex2_mul_hl) << HALF)
                   + PW'(ex2_mul_ll);
    assign prod_hi = product[PW-1:`EXU_XLEN];

    always_comb begin
        case (ex2_uop)
            UOP_MUL_LO: result = product[`EXU_XLEN-1:0];
            UOP_MULH_U: result = prod_hi;
            UOP_MULH_S: result = prod_hi - ex2_mul_compensate;
            default:    result = ex2_alu_result;
        endcase
    end

    assign ex2_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (ex2_ready) begin
            out_valid <= ex2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex2_valid && ex2_ready) begin
            out_pc        <= ex2_pc;
            out_rd        <= ex2_rd;
            out_excp_flag <= ex2_excp_flag;
            out_data      <= ex2_excp_flag ? '0 : result;
            out_exception <= ex2_excp_flag ? EXC_INE : 7'h00;
        end
    end

endmodule

// ==== hw/exu_top.sv ====
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_top import exu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`EXU_XLEN-1:0]     in_pc,
    input  logic [`EXU_XLEN-1:0]     in_inst,
    input  logic [`EXU_XLEN-1:0]     in_rj_data,
    input  logic [`EXU_XLEN-1:0]     in_rk_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`EXU_XLEN-1:0]     out_pc,
    output logic [`EXU_REG_BITS-1:0] out_rd,
    output logic [`EXU_XLEN-1:0]     out_data,
    output logic                     out_excp_flag,
    output logic [6:0]               out_exception
);

    // decode slot
    logic                     dec_valid;
    logic                     dec_ready;
    logic [`EXU_XLEN-1:0]     dec_pc;
    exu_uop_t                 dec_uop;
    logic [`EXU_XLEN-1:0]     dec_src1;
    logic [`EXU_XLEN-1:0]     dec_src2;
    logic [`EXU_REG_BITS-1:0] dec_rd;
    logic                     dec_excp_flag;

    // stage 1 combinational results
    logic [`EXU_XLEN-1:0]     alu_result;
    logic [`EXU_XLEN-1:0]     mul_ll;
    logic [`EXU_XLEN-1:0]     mul_lh;
    logic [`EXU_XLEN-1:0]     mul_hl;
    logic [`EXU_XLEN-1:0]     mul_hh;
    logic [`EXU_XLEN-1:0]     mul_compensate;

    // ex1/ex2 slot
    logic                     ex2_valid;
    logic                     ex2_ready;
    logic [`EXU_XLEN-1:0]     ex2_pc;
    exu_uop_t                 ex2_uop;
    logic [`EXU_REG_BITS-1:0] ex2_rd;
    logic                     ex2_excp_flag;
    logic [`EXU_XLEN-1:0]     ex2_alu_result;
    logic [`EXU_XLEN-1:0]     ex2_mul_ll;
    logic [`EXU_XLEN-1:0]     ex2_mul_lh;
    logic [`EXU_XLEN-1:0]     ex2_mul_hl;
    logic [`EXU_XLEN-1:0]     ex2_mul_hh;
    logic [`EXU_XLEN-1:0]     ex2_mul_compensate;

    exu_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_rj_data    (in_rj_data),
        .in_rk_data    (in_rk_data),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_pc        (dec_pc),
        .dec_uop       (dec_uop),
        .dec_src1      (dec_src1),
        .dec_src2      (dec_src2),
        .dec_rd        (dec_rd),
        .dec_excp_flag (dec_excp_flag)
    );

    exu_ex1 u_ex1 (
        .uop            (dec_uop),
        .src1           (dec_src1),
        .src2           (dec_src2),
        .alu_result     (alu_result),
        .mul_ll         (mul_ll),
        .mul_lh         (mul_lh),
        .mul_hl         (mul_hl),
        .mul_hh         (mul_hh),
        .mul_compensate (mul_compensate)
    );

    exu_ex1_ex2 u_ex1_ex2 (
        .clk                (clk),
        .reset              (reset),
        .flush              (flush),
        .dec_valid          (dec_valid),
        .dec_ready          (dec_ready),
        .dec_pc             (dec_pc),
        .dec_uop            (dec_uop),
        .dec_rd             (dec_rd),
        .dec_excp_flag      (dec_excp_flag),
        .alu_result         (alu_result),
        .mul_ll             (mul_ll),
        .mul_lh             (mul_lh),
        .mul_hl             (mul_hl),
        .mul_hh             (mul_hh),
        .mul_compensate     (mul_compensate),
        .ex2_valid          (ex2_valid),
        .ex2_ready          (ex2_ready),
        .ex2_pc             (ex2_pc),
        .ex2_uop            (ex2_uop),
        .ex2_rd             (ex2_rd),
        .ex2_excp_flag      (ex2_excp_flag),
        .ex2_alu_result     (ex2_alu_result),
        .ex2_mul_ll         (ex2_mul_ll),
        .ex2_mul_lh         (ex2_mul_lh),
        .ex2_mul_hl         (ex2_mul_hl),
        .ex2_mul_hh         (ex2_mul_hh),
        .ex2_mul_compensate (ex2_mul_compensate)
    );

    exu_result u_result (
        .clk                (clk),
        .reset              (reset),
        .flush              (flush),
        .ex2_valid          (ex2_valid),
        .ex2_ready          (ex2_ready),
        .ex2_pc             (ex2_pc),
        .ex2_uop            (ex2_uop),
        .ex2_rd             (ex2_rd),
        .ex2_excp_flag      (ex2_excp_flag),
        .ex2_alu_result     (ex2_alu_result),
        .ex2_mul_ll         (ex2_mul_ll),
        .ex2_mul_lh         (ex2_mul_lh),
        .ex2_mul_hl         (ex2_mul_hl),
        .ex2_mul_hh         (ex2_mul_hh),
        .ex2_mul_compensate (ex2_mul_compensate),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_pc             (out_pc),
        .out_rd             (out_rd),
        .out_data           (out_data),
        .out_excp_flag      (out_excp_flag),
        .out_exception      (out_exception)
    );

endmodule

// ==== tb/exu_top_properties.sv ====
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_top_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     flush,
    input logic                     dec_valid,
    input logic                     ex2_valid,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [`EXU_XLEN-1:0]     out_pc,
    input logic [`EXU_REG_BITS-1:0] out_rd,
    input logic [`EXU_XLEN-1:0]     out_data,
    input logic                     out_excp_flag,
    input logic [6:0]               out_exception
);

    // number of failed assertions so far
    int failures = 0;

    // stalled output keeps its payload unless a flush kills it
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_pc)
            && $stable(out_rd) && $stable(out_data)
            && $stable(out_excp_flag) && $stable(out_exception))
        else begin
            failures++;
            $error("output payload changed while stalled");
        end

    empty_after_reset: assert property (@(posedge clk)
        reset |=> !dec_valid && !ex2_valid && !out_valid)
        else begin
            failures++;
            $error("valid high after reset");
        end

    empty_after_flush: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out_valid)
        else begin
            failures++;
            $error("out_valid high after flush");
        end

endmodule

bind exu_top exu_top_properties u_properties (
    .clk           (clk),
    .reset         (reset),
    .flush         (flush),
    .dec_valid     (dec_valid),
    .ex2_valid     (ex2_valid),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_rd        (out_rd),
    .out_data      (out_data),
    .out_excp_flag (out_excp_flag),
    .out_exception (out_exception)
);

// ==== tb/tb_exu_top.sv ====
`timescale 1ns/1ps
`include "exu_settings.svh"

module tb_exu_top import exu_pkg::*; ();

    logic                     clk;
    logic                     reset;
    logic                     flush;
    logic                     in_valid;
    logic                     in_ready;
    logic [`EXU_XLEN-1:0]     in_pc;
    logic [`EXU_XLEN-1:0]     in_inst;
    logic [`EXU_XLEN-1:0]     in_rj_data;
    logic [`EXU_XLEN-1:0]     in_rk_data;
    logic                     out_valid;
    logic                     out_ready;
    logic [`EXU_XLEN-1:0]     out_pc;
    logic [`EXU_REG_BITS-1:0] out_rd;
    logic [`EXU_XLEN-1:0]     out_data;
    logic                     out_excp_flag;
    logic [6:0]               out_exception;

    int          errors = 0;
    int          seed = 32'h8d34_63d6;
    bit          random_ready = 0;
    logic [31:0] next_pc = 32'h1c00_0000;
    logic [39:0] exp_q[$];
    logic [31:0] pc_q[$];
    logic [`EXU_REG_BITS-1:0] rd_q[$];
    logic [16:0] r3_ops[9] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_AND, OP_OR, OP_XOR,
                               OP_MUL_W, OP_MULH_W, OP_MULH_WU};
    logic [9:0]  ri_ops[4] = '{OP_SLTI, OP_ADDI_W, OP_ANDI, OP_ORI};
    logic [31:0] corners[5] = '{32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h1, 32'h7fff_ffff};

    exu_top uut (.*);

    initial begin
        clk = 0;
        forever #20 clk = ~clk;
    end

    // {exception, excp_flag, data}
    function automatic logic [39:0] exp_result(input logic [31:0] inst,
                                               input logic [31:0] rj, input logic [31:0] rk);
        logic [31:0] d;
        logic [31:0] imms;
        logic [31:0] immu;
        logic [63:0] p;
        logic        ok;
        imms = {{20{inst[21]}}, inst[21:10]};
        immu = {20'h0, inst[21:10]};
        ok = 1'b1;
        d = '0;
        case (inst[31:15])
            OP_ADD_W:   d = rj + rk;
            OP_SUB_W:   d = rj - rk;
            OP_SLT:     d = {31'h0, $signed(rj) < $signed(rk)};
            OP_AND:     d = rj & rk;
            OP_OR:      d = rj | rk;
            OP_XOR:     d = rj ^ rk;
            OP_MUL_W:   d = rj * rk;
            OP_MULH_W: begin
                p = $signed({{32{rj[31]}}, rj}) * $signed({{32{rk[31]}}, rk});
                d = p[63:32];
            end
            OP_MULH_WU: begin
                p = {32'h0, rj} * {32'h0, rk};
                d = p[63:32];
            end
            default: begin
                case (inst[31:22])
                    OP_SLTI:   d = {31'h0, $signed(rj) < $signed(imms)};
                    OP_ADDI_W: d = rj + imms;
                    OP_ANDI:   d = rj & immu;
                    OP_ORI:    d = rj | immu;
                    default:   ok = 1'b0;
                endcase
            end
        endcase
        return ok ? {7'h00, 1'b0, d} : {EXC_INE, 1'b1, 32'h0};
    endfunction

    task automatic check(input string name, input logic [39:0] got, input logic [39:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // output compare first, then flush or input bookkeeping
    always @(posedge clk) begin
        logic [39:0] e;
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result for pc %h appeared with nothing outstanding", out_pc);
            end else begin
                e = exp_q.pop_front();
                check("out_data", 40'(out_data), 40'(e[31:0]));
                check("out_excp_flag", 40'(out_excp_flag), 40'(e[32]));
                check("out_exception", 40'(out_exception), 40'(e[39:33]));
                check("out_pc", 40'(out_pc), 40'(pc_q.pop_front()));
                check("out_rd", 40'(out_rd), 40'(rd_q.pop_front()));
            end
        end
        if (flush) begin
            exp_q.delete();
            pc_q.delete();
            rd_q.delete();
        end else if (!reset && in_valid && in_ready) begin
            exp_q.push_back(exp_result(in_inst, in_rj_data, in_rk_data));
            pc_q.push_back(in_pc);
            rd_q.push_back(in_inst[4:0]);
        end
    end

    always @(posedge clk) begin
        out_ready <= random_ready ? 1'($random(seed)) : 1'b1;
    end

    // called just after a rising edge, returns just after the accepting edge
    task automatic issue(input logic [31:0] inst, input logic [31:0] rj, input logic [31:0] rk);
        int n;
        in_valid   <= 1'b1;
        in_pc      <= next_pc;
        in_inst    <= inst;
        in_rj_data <= rj;
        in_rk_data <= rk;
        next_pc = next_pc + 4;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 100)
                timeout_abort("in_ready");
        end while (!in_ready);
        // with out_ready held high a back-to-back stream never stalls
        if (!random_ready && n != 1) begin
            errors++;
            $display("in_ready was low for %0d cycles with out_ready held high", n - 1);
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 500)
                timeout_abort("pipeline to drain");
        end
    endtask

    function automatic logic [31:0] rand_inst();
        logic [31:0] r;
        r = $random(seed);
        if (r[31])
            return {r3_ops[r[3:0] % 4'd9], r[14:0]};
        return {ri_ops[r[1:0]], r[21:0]};
    endfunction

    function automatic logic [31:0] undefined_word();
        logic [31:0] w;
        logic [39:0] e;
        w = $random(seed);
        e = exp_result(w, 0, 0);
        while (!e[32]) begin
            w = $random(seed);
            e = exp_result(w, 0, 0);
        end
        return w;
    endfunction

    initial begin
        int n;
        reset = 1;
        flush = 0;
        in_valid = 0;
        in_pc = '0;
        in_inst = '0;
        in_rj_data = '0;
        in_rk_data = '0;
        out_ready = 1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // latency of a lone instruction
        issue({OP_ADD_W, 15'h0421}, 32'd5, 32'd7);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!out_valid && n < 20);
        if (n != 3) begin
            errors++;
            $display("first result took %0d cycles instead of 3", n);
        end
        @(posedge clk);

        // random ALU, immediate and multiply stream
        repeat (300) issue(rand_inst(), $random(seed), $random(seed));
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                issue({OP_MUL_W, 15'h0c41}, corners[i], corners[j]);
                issue({OP_MULH_W, 15'h0c42}, corners[i], corners[j]);
                issue({OP_MULH_WU, 15'h0c43}, corners[i], corners[j]);
            end
        end
        repeat (40) issue(undefined_word(), $random(seed), $random(seed));
        drain();

        // back-pressure on the output
        random_ready = 1;
        repeat (200) issue(rand_inst(), $random(seed), $random(seed));
        drain();

        // flush mid-stream, offering one more word in the flush cycle
        repeat (5) issue(rand_inst(), $random(seed), $random(seed));
        flush      <= 1'b1;
        in_valid   <= 1'b1;
        in_inst    <= {OP_ADD_W, 15'h0};
        @(posedge clk);
        flush    <= 1'b0;
        in_valid <= 1'b0;
        repeat (6) @(posedge clk);
        random_ready = 0;
        repeat (50) issue(rand_inst(), $random(seed), $random(seed));
        drain();
        repeat (4) @(posedge clk);

        $display("checks done, errors: %0d, assertion failures: %0d", errors,
                 uut.u_properties.failures);
        if (errors == 0 && uut.u_properties.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== exu_top.f ====
+incdir+include
hw/exu_pkg.sv
hw/exu_decode.sv
hw/exu_ex1.sv
hw/exu_ex1_ex2.sv
hw/exu_result.sv
hw/exu_top.sv
tb/exu_top_properties.sv
tb/tb_exu_top.sv

// ==== Makefile ====
SRCS := $(wildcard hw/*.sv tb/*.sv include/*.svh) exu_top.f

.PHONY: all run clean

all: run

obj_dir/Vtb_exu_top: $(SRCS)
	verilator --binary --timing --assert --top-module tb_exu_top \
		-f exu_top.f -o Vtb_exu_top

sim.log: obj_dir/Vtb_exu_top
	./obj_dir/Vtb_exu_top > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
